/* common/ti_mem_pkg.sv */
//==========================================================================
// ti_mem_pkg
// shared widths, types and address map of the TI-99/4A on-chip memory
// subsystem (scratchpad, GROM extension, 32K RAM expansion)
//==========================================================================

`default_nettype none

package ti_mem_pkg;

  //==========================================================================
  // bus and memory widths
  //==========================================================================
  localparam int adr_w  = 23;             // word address, byte addr bits 23..1
  localparam int dat_w  = 16;             // cpu data word
  localparam int sel_w  = 2;              // byte lanes, bit 0 = low byte
  localparam int lane_w = dat_w / sel_w;  // bits per lane
  localparam int pad_aw = 9;              // 512 words = 1K byte scratchpad
  localparam int big_aw = 14;             // 16K words = 32K byte
  localparam int idx_w  = big_aw;         // widest local index between stages

  typedef logic [adr_w-1:0] adr_t;
  typedef logic [dat_w-1:0] dat_t;
  typedef logic [sel_w-1:0] sel_t;
  typedef logic [idx_w-1:0] idx_t;

  // decoded target of one access
  typedef enum logic [1:0] {
    region_none     = 2'd0,  // unmapped, reads 0, writes dropped
    region_pad      = 2'd1,
    region_grom_ext = 2'd2,
    region_ram_exp  = 2'd3
  } region_e;

  //==========================================================================
  // address map, all on word address bits
  //==========================================================================
  // scratchpad, bits 22..9, byte 8000
  localparam logic [13:0] pad_base    = 14'b0000_0000_1000_00;
  // grom space, bits 22..15, byte 10000
  localparam logic [7:0]  grom_page   = 8'b0000_0001;
  // writable grom chunks on bits 14..12, 3 up to 6
  localparam logic [2:0]  grom_ext_lo = 3'd3;
  localparam logic [2:0]  grom_ext_hi = 3'd6;

  // 32K expansion windows
  localparam logic [10:0] ram_lo_page = 11'b000_0000_0001;  // 2000..3fff, bits 22..12
  localparam logic [10:0] ram_a_page  = 11'b000_0000_0101;  // a000..bfff, bits 22..12
  localparam logic [9:0]  ram_c_page  = 10'b00_0000_0011;   // c000..ffff, bits 22..13
  // chunk on bits 14..12 that folds down to index quarter 0
  localparam logic [2:0]  ram_fold_chunk = 3'b001;

  // edges from accepting stb to ack
  localparam int lat_cycles = 2;

endpackage

`default_nettype wire

/* rtl/byte_lane_ram.sv */
//==========================================================================
// byte_lane_ram
// word addressed block ram, registered read, one write enable per byte lane
//==========================================================================

`default_nettype none

module byte_lane_ram #(
  parameter int aw = ti_mem_pkg::pad_aw  // word index width
) (
  input  logic              clk,
  input  ti_mem_pkg::sel_t  i_we,    // per lane write enable
  input  logic [aw-1:0]     i_addr,
  input  ti_mem_pkg::dat_t  i_dat,
  output ti_mem_pkg::dat_t  o_dat
);
  import ti_mem_pkg::*;

  dat_t mem [2**aw];

  always_ff @(posedge clk)
  begin
    for (int l = 0; l < sel_w; l++)
    begin
      if (i_we[l])
        mem[i_addr][l*lane_w +: lane_w] <= i_dat[l*lane_w +: lane_w];
    end
    o_dat <= mem[i_addr];  // read first, old word on a write
  end

endmodule

`default_nettype wire

/* rtl/mem_decode.sv */
//==========================================================================
// mem_decode
// first pipeline stage that takes a wishbone classic request when idle,
// decodes its region, folds the expansion address and registers the access
//==========================================================================

`default_nettype none

module mem_decode (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  ti_mem_pkg::adr_t     i_wb_adr,
  input  ti_mem_pkg::sel_t     i_wb_sel,
  input  ti_mem_pkg::dat_t     i_wb_dat,
  input  logic                 i_ack,     // ack from the access stage
  output logic                 o_valid,
  output logic                 o_we,
  output ti_mem_pkg::sel_t     o_sel,
  output ti_mem_pkg::region_e  o_region,
  output ti_mem_pkg::idx_t     o_idx,
  output ti_mem_pkg::dat_t     o_dat
);
  import ti_mem_pkg::*;

  logic    busy;     // one access in flight
  logic    accept;
  logic    pad_hit, grom_hit, ram_hit;
  logic    ram_fold;
  region_e region;
  idx_t    idx;

  assign accept = i_wb_cyc && i_wb_stb && !busy;

  //==========================================================================
  // address decode
  //==========================================================================
  assign pad_hit  = (i_wb_adr[adr_w-1:9] == pad_base);
  assign grom_hit = (i_wb_adr[adr_w-1:15] == grom_page)
                 && (i_wb_adr[14:12] >= grom_ext_lo)
                 && (i_wb_adr[14:12] <= grom_ext_hi);    // pages 0,1,2,7 unmapped
  assign ram_hit  = (i_wb_adr[adr_w-1:12] == ram_lo_page)
                 || (i_wb_adr[adr_w-1:12] == ram_a_page)
                 || (i_wb_adr[adr_w-1:13] == ram_c_page);
  // 2000 window shares bits 13..12 with a000 so it moves to quarter 0
  assign ram_fold = (i_wb_adr[14:12] == ram_fold_chunk);

  always_comb
  begin
    region = region_none;
    idx    = '0;
    if (pad_hit)
    begin
      region = region_pad;
      idx    = idx_t'(i_wb_adr[pad_aw-1:0]);  // zero extended
    end
    else if (grom_hit)
    begin
      region = region_grom_ext;                // writable ram in this design
      idx    = i_wb_adr[idx_w-1:0];
    end
    else if (ram_hit)
    begin
      region = region_ram_exp;
      idx    = {(ram_fold ? 2'b00 : i_wb_adr[13:12]), i_wb_adr[11:0]};
    end
  end

  //==========================================================================
  // request register
  //==========================================================================
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      busy    <= 1'b0;
      o_valid <= 1'b0;
    end
    else
    begin
      o_valid <= accept;  // one pulse per accepted request
      if (accept)
        busy <= 1'b1;
      else if (i_ack)
        busy <= 1'b0;
    end
  end

  // request payload for stage 2
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      o_we     <= i_wb_we;
      o_sel    <= i_wb_sel;
      o_region <= region;
      o_idx    <= idx;
      o_dat    <= i_wb_dat;
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_valid |=> !o_valid);
  // busy lasts up to the ack edge so the next request waits past it
  a_valid_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_valid |-> ##lat_cycles !o_valid);
  // ack from stage 2 lands at the fixed bus latency
  a_ack_lat: assert property (@(posedge clk) disable iff (!i_arst_n)
    accept |-> ##lat_cycles i_ack);

endmodule

`default_nettype wire

/* rtl/mem_access.sv */
//==========================================================================
// mem_access
// stage 2, writes or reads the scratchpad, grom extension and ram expansion,
// picks the read word by the registered region and raises wishbone ack
//==========================================================================

`default_nettype none

module mem_access (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_valid,
  input  logic                 i_we,
  input  ti_mem_pkg::sel_t     i_sel,
  input  ti_mem_pkg::region_e  i_region,
  input  ti_mem_pkg::idx_t     i_idx,
  input  ti_mem_pkg::dat_t     i_dat,
  output ti_mem_pkg::dat_t     o_wb_dat,
  output logic                 o_wb_ack
);
  import ti_mem_pkg::*;

  sel_t    lane_we;                          // lanes of a valid write
  sel_t    pad_we, grom_we, ram_we;
  dat_t    pad_q, grom_q, ram_q;             // registered ram outputs
  region_e region_q;
  logic    rd_q;                             // read in the ack cycle

  //==========================================================================
  // write enables
  //==========================================================================
  assign lane_we = (i_valid && i_we) ? i_sel : '0;
  assign pad_we  = (i_region == region_pad)      ? lane_we : '0;
  assign grom_we = (i_region == region_grom_ext) ? lane_we : '0;
  assign ram_we  = (i_region == region_ram_exp)  ? lane_we : '0;
  // region_none falls through, write dropped

  byte_lane_ram #(.aw(pad_aw)) u_pad (
    .clk    (clk),
    .i_we   (pad_we),
    .i_addr (i_idx[pad_aw-1:0]),
    .i_dat  (i_dat),
    .o_dat  (pad_q)
  );

  byte_lane_ram #(.aw(big_aw)) u_grom_ext (
    .clk    (clk),
    .i_we   (grom_we),
    .i_addr (i_idx),
    .i_dat  (i_dat),
    .o_dat  (grom_q)
  );

  byte_lane_ram #(.aw(big_aw)) u_ram_exp (
    .clk    (clk),
    .i_we   (ram_we),
    .i_addr (i_idx),
    .i_dat  (i_dat),
    .o_dat  (ram_q)
  );

  //==========================================================================
  // read select and ack
  //==========================================================================
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_wb_ack <= 1'b0;
      rd_q     <= 1'b0;
      region_q <= region_none;
    end
    else
    begin
      o_wb_ack <= i_valid;            // same edge as the ram access
      rd_q     <= i_valid && !i_we;
      if (i_valid)
        region_q <= i_region;
    end
  end

  always_comb
  begin
    o_wb_dat = '0;                    // writes and unmapped give 0
    if (rd_q)
    begin
      case (region_q)
        region_pad:      o_wb_dat = pad_q;
        region_grom_ext: o_wb_dat = grom_q;
        region_ram_exp:  o_wb_dat = ram_q;
        default:         o_wb_dat = '0;
      endcase
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

/* rtl/ti_mem_top.sv */
//==========================================================================
// ti_mem_top
// writable ti-99/4a memory map behind a wishbone classic slave port,
// decode stage followed by the memory access stage
//==========================================================================

`default_nettype none

module ti_mem_top (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  ti_mem_pkg::adr_t  i_wb_adr,   // word address
  input  ti_mem_pkg::sel_t  i_wb_sel,
  input  ti_mem_pkg::dat_t  i_wb_dat,
  output ti_mem_pkg::dat_t  o_wb_dat,
  output logic              o_wb_ack
);
  import ti_mem_pkg::*;

  // stage 1 to stage 2
  logic    s1_valid;
  logic    s1_we;
  sel_t    s1_sel;
  region_e s1_region;
  idx_t    s1_idx;
  dat_t    s1_dat;

  mem_decode u_decode (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_sel (i_wb_sel),
    .i_wb_dat (i_wb_dat),
    .i_ack    (o_wb_ack),   // clears busy
    .o_valid  (s1_valid),
    .o_we     (s1_we),
    .o_sel    (s1_sel),
    .o_region (s1_region),
    .o_idx    (s1_idx),
    .o_dat    (s1_dat)
  );

  mem_access u_access (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (s1_valid),
    .i_we     (s1_we),
    .i_sel    (s1_sel),
    .i_region (s1_region),
    .i_idx    (s1_idx),
    .i_dat    (s1_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack)
  );

endmodule

`default_nettype wire

/* tests/tb_ti_mem.sv */
//==========================================================================
// tb_ti_mem
// testbench for the ti-99/4a memory map, wishbone classic master tasks,
// shadow reference model and a checker that compares every acknowledge
//==========================================================================

`default_nettype none

module tb_ti_mem;
  import ti_mem_pkg::*;

  localparam int ack_timeout = 20;  // cycles one transfer may wait
  localparam int pool_n      = 24;  // addresses of the random test

  logic   clk;
  logic   i_arst_n;
  logic   i_wb_cyc, i_wb_stb, i_wb_we;
  adr_t   i_wb_adr;
  sel_t   i_wb_sel;
  dat_t   i_wb_dat;
  dat_t   o_wb_dat;
  logic   o_wb_ack;

  dat_t   shadow [int];             // expected ram contents
  dat_t   exp_q [$];                // expected word per request
  adr_t   adr_q [$];
  adr_t   pool [pool_n];
  adr_t   win [4] = '{23'h1000, 23'h5000, 23'h6000, 23'h7000};  // 2000 a000 c000 e000
  int     err_cnt, chk_cnt, test_cnt, test_fail;
  int     lat_cnt;
  logic   in_flight;
  integer seed;

  ti_mem_top dut (
    .clk(clk), .i_arst_n(i_arst_n), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_sel(i_wb_sel),
    .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack)
  );

  always #10 clk = ~clk;

  //==========================================================================
  // reference model
  //==========================================================================
  function automatic region_e ref_map(input adr_t adr, output idx_t idx);
    region_e rgn;
    rgn = region_none;
    idx = '0;
    if (adr[22:9] == pad_base)
    begin
      rgn = region_pad;
      idx = idx_t'(adr[8:0]);
    end
    else if (adr[22:15] == grom_page && adr[14:12] >= 3'd3 && adr[14:12] <= 3'd6)
    begin
      rgn = region_grom_ext;
      idx = adr[13:0];
    end
    else if (adr[22:12] == ram_lo_page || adr[22:12] == ram_a_page
             || adr[22:13] == ram_c_page)
    begin
      rgn = region_ram_exp;
      idx = adr[13:0];
      if (adr[14:12] == 3'b001)
        idx[13:12] = 2'b00;         // 2000 window lands in quarter 0
    end
    return rgn;
  endfunction

  function automatic int map_key(input region_e rgn, input idx_t idx);
    return int'(rgn) * 65536 + int'(idx);
  endfunction

  function automatic void shadow_write(input adr_t adr, input sel_t sel, input dat_t dat);
    region_e rgn;
    idx_t    idx;
    dat_t    word;
    rgn = ref_map(adr, idx);
    if (rgn != region_none)        // unmapped writes vanish
    begin
      word = shadow.exists(map_key(rgn, idx)) ? shadow[map_key(rgn, idx)] : 'x;
      if (sel[0])
        word[7:0] = dat[7:0];
      if (sel[1])
        word[15:8] = dat[15:8];
      shadow[map_key(rgn, idx)] = word;
    end
  endfunction

  function automatic dat_t ref_read(input adr_t adr);
    region_e rgn;
    idx_t    idx;
    rgn = ref_map(adr, idx);
    if (rgn == region_none)
      return '0;
    return shadow.exists(map_key(rgn, idx)) ? shadow[map_key(rgn, idx)] : 'x;
  endfunction

  //==========================================================================
  // compare tasks
  //==========================================================================
  task automatic check_dat(input string name, input dat_t got, input dat_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ack_lat(input int got, input int exp);
    chk_cnt++;
    if (got != exp)
    begin
      err_cnt++;
      $display("FAILED t=%0t o_wb_ack latency got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // checker counts latency from the edge that first samples stb
  always @(posedge clk)
  begin
    if (!i_arst_n)
      in_flight = 1'b0;
    else
    begin
      if (in_flight)
        lat_cnt++;
      else if (i_wb_cyc && i_wb_stb)
      begin
        in_flight = 1'b1;
        lat_cnt   = 0;
      end
      if (o_wb_ack)
      begin
        if (exp_q.size() == 0)
        begin
          err_cnt++;
          $display("acknowledge at time %0t without any pending request", $time);
        end
        else
        begin
          check_ack_lat(lat_cnt, lat_cycles);
          check_dat($sformatf("o_wb_dat @%h", adr_q.pop_front()), o_wb_dat, exp_q.pop_front());
        end
        in_flight = 1'b0;
      end
    end
  end

  //==========================================================================
  // bus tasks
  //==========================================================================
  task automatic run_xfer(input logic we, input adr_t adr, input sel_t sel, input dat_t dat);
    int   n;
    logic acked;
    @(posedge clk);
    if (we)
    begin
      shadow_write(adr, sel, dat);
      exp_q.push_back('0);          // write ack returns 0
    end
    else
      exp_q.push_back(ref_read(adr));
    adr_q.push_back(adr);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_sel <= sel;
    i_wb_dat <= dat;
    acked = 1'b0;
    n     = 0;
    while (!acked && n < ack_timeout)
    begin
      @(posedge clk);
      acked = o_wb_ack;
      n++;
    end
    i_wb_cyc <= 1'b0;               // drop on the ack edge
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    if (!acked)
    begin
      err_cnt++;
      $display("no acknowledge within %0d cycles for %s at address %h",
               ack_timeout, we ? "write" : "read", adr);
      exp_q.delete();
      adr_q.delete();
    end
    @(negedge clk);                 // checker done with this edge
  endtask

  task automatic write_word(input adr_t adr, input sel_t sel, input dat_t dat);
    run_xfer(1'b1, adr, sel, dat);
  endtask

  task automatic read_word(input adr_t adr);
    run_xfer(1'b0, adr, 2'b11, '0);
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %0d %s ok", test_cnt, name);
    else
    begin
      test_fail++;
      $display("test %0d %s failed with %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  //==========================================================================
  // test sequence
  //==========================================================================
  initial
  begin
    int          e0;
    int          k;
    adr_t        a;
    logic [31:0] r;
    clk      = 1'b0;
    i_arst_n = 1'b0;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_sel = '0;
    i_wb_dat = '0;
    seed     = 32'h781f;
    repeat (10) @(posedge clk);
    i_arst_n <= 1'b1;

    e0 = err_cnt;                   // idle after reset then an unmapped read
    repeat (5)
    begin
      @(posedge clk);
      check_flag("o_wb_ack", o_wb_ack, 1'b0);
    end
    read_word(23'h0);
    report_test("reset and first read", e0);

    e0 = err_cnt;                   // four expansion chunks without aliasing
    for (k = 0; k < 8; k++)
      write_word(win[k % 4] + (k / 4) * 23'h123, 2'b11, dat_t'(16'hc000 + k * 16'h0111));
    for (k = 0; k < 8; k++)
      read_word(win[k % 4] + (k / 4) * 23'h123);
    report_test("ram expansion chunks", e0);

    e0 = err_cnt;                   // scratchpad lane merge
    write_word(23'h4010, 2'b11, 16'h1234);
    write_word(23'h4010, 2'b01, 16'hffcd);
    read_word(23'h4010);
    write_word(23'h4010, 2'b10, 16'h5eff);
    read_word(23'h4010);
    write_word(23'h41ff, 2'b11, 16'hbeef);
    write_word(23'h41ff, 2'b00, 16'h0000);  // no lane written
    read_word(23'h41ff);
    report_test("scratchpad byte lanes", e0);

    e0 = err_cnt;                   // grom pages 3..6 hold data but not 0 and 7
    for (k = 0; k < 8; k++)
      write_word(23'h8000 | (adr_t'(k) << 12) | 23'h0a5, 2'b11, dat_t'(16'h3c00 + k));
    for (k = 0; k < 8; k++)
      read_word(23'h8000 | (adr_t'(k) << 12) | 23'h0a5);
    report_test("grom extension", e0);

    e0 = err_cnt;                   // unmapped writes dropped
    write_word(23'h0000, 2'b11, 16'hdead);
    write_word(23'h0800, 2'b11, 16'hface);
    write_word(23'h0010, 2'b11, 16'hffff);  // same low bits as pad word
    read_word(23'h0000);
    read_word(23'h0800);
    read_word(23'h0010);
    read_word(23'h4010);
    report_test("unmapped writes", e0);

    e0 = err_cnt;                   // random mix over a prefilled pool
    for (k = 0; k < pool_n; k++)
    begin
      r = $random(seed);
      case (k % 6)
        0:       pool[k] = 23'h4000 | (adr_t'(r) & 23'h01ff);
        1:       pool[k] = 23'h8000 | (adr_t'(3 + (k / 6) % 4) << 12) | (adr_t'(r) & 23'h0fff);
        2:       pool[k] = 23'h1000 | (adr_t'(r) & 23'h0fff);
        3:       pool[k] = 23'h5000 | (adr_t'(r) & 23'h0fff);
        4:       pool[k] = 23'h6000 | (adr_t'(r) & 23'h1fff);
        default: pool[k] = ((k / 6) % 2 ? 23'hf000 : 23'h0000) | (adr_t'(r) & 23'h0fff);
      endcase
      write_word(pool[k], 2'b11, dat_t'($random(seed)));
    end
    for (k = 0; k < 300; k++)
    begin
      r = $random(seed);
      a = pool[$unsigned($random(seed)) % pool_n];
      if (r[0])
        write_word(a, r[2:1], r[31:16]);
      else
        read_word(a);
    end
    report_test("random accesses", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/ti_mem_pkg.sv
rtl/byte_lane_ram.sv
rtl/mem_decode.sv
rtl/mem_access.sv
rtl/ti_mem_top.sv
tests/tb_ti_mem.sv

/* Bender.yml */
package:
  name: ti_mem

# package first, then leaf modules, then the top level
sources:
  - common/ti_mem_pkg.sv
  - rtl/byte_lane_ram.sv
  - rtl/mem_decode.sv
  - rtl/mem_access.sv
  - rtl/ti_mem_top.sv
  - target: test
    files:
      - tests/tb_ti_mem.sv
